/* filelist.f */
+incdir+.
character_pkg.sv
character_ifs.sv
button_sampler.sv
jump_fsm.sv
character_physics.sv
character_top.sv
tb_character.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the character testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module tb_character -o tb_character
./obj_dir/tb_character > sim.log
cat sim.log

if grep -q "Errors found" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

/* character_model.svh */
// ----------------------------------------
// reference model of the character
// sampler, FSM and physics, one step per edge
// ----------------------------------------
`ifndef CHARACTER_MODEL_SVH
`define CHARACTER_MODEL_SVH

localparam int LO_X = int'(X_MIN);
localparam int HI_X = int'(X_MAX);
localparam int LO_Y = int'(Y_MIN);
localparam int HI_Y = int'(Y_MAX);
localparam int VMAX = int'(MAX_VEL);

int          m_px, m_py, m_vx, m_vy;
int          m_face;
int          m_charge;
move_state_t m_state;
logic        m_left_q, m_right_q, m_jump_q;    // button samples of the last edge
logic        m_left_p, m_right_p, m_jump_p;    // pending commands

function automatic int limit_to(input int v, input int lo, input int hi);
    if (v < lo) return lo;
    if (v > hi) return hi;
    return v;
endfunction

task automatic model_reset();
    m_px      = int'(INIT_X);
    m_py      = int'(INIT_Y);
    m_vx      = 0;
    m_vy      = 0;
    m_face    = 1;
    m_charge  = int'(CHARGE_INIT);
    m_state   = ST_IDLE;
    m_left_q  = 1'b0;
    m_right_q = 1'b0;
    m_jump_q  = 1'b0;
    m_left_p  = 1'b0;
    m_right_p = 1'b0;
    m_jump_p  = 1'b0;
endtask

task automatic model_step(input logic l, input logic r, input logic j);
    logic        ground;
    logic        bounce;
    logic        take_now;
    int          factor;
    int          vx;
    int          vy;
    int          walk;
    move_state_t nxt;
    ground = (m_py == LO_Y);
    bounce = (m_px == HI_X && m_vx > 0) || (m_px == LO_X && m_vx < 0);
    if (m_charge <= int'(MAX_CHARGE) / 4) factor = 1;
    else if (m_charge <= int'(MAX_CHARGE) / 2) factor = 2;
    else if (m_charge <= int'(MAX_CHARGE) * 3 / 4) factor = 3;
    else factor = 4;

    // movement state and command take
    take_now = 1'b0;
    nxt      = ST_IDLE;
    if (m_state == ST_CHARGE) begin
        nxt = (m_charge >= int'(MAX_CHARGE) || !m_jump_q) ? ST_JUMP : ST_CHARGE;
    end else if (m_state != ST_JUMP && ground) begin
        take_now = m_left_p | m_right_p | m_jump_p;
        if (m_left_p) nxt = ST_WALK_LEFT;
        else if (m_right_p) nxt = ST_WALK_RIGHT;
        else if (m_jump_p) nxt = ST_CHARGE;
    end

    // contact response, impulse, gravity, saturation
    vx = m_vx;
    vy = m_vy;
    if (ground && m_vy < 0) begin
        vx = 0;
        vy = 0;
    end else begin
        if (bounce) vx = -vx;
        if (m_py == HI_Y && m_vy > 0) vy = -vy;
    end
    if (m_state == ST_JUMP) begin
        vx = vx + int'(JUMP_VEL_X) * factor * m_face;
        vy = vy + int'(JUMP_VEL_Y) * factor;
    end
    if (!ground) vy = vy + int'(GRAVITY);
    vx = limit_to(vx, -VMAX, VMAX);
    vy = limit_to(vy, -VMAX, VMAX);
    walk = 0;
    if (m_state == ST_WALK_LEFT) walk = int'(WALK_LEFT_STEP);
    if (m_state == ST_WALK_RIGHT) walk = int'(WALK_RIGHT_STEP);
    m_px = limit_to(m_px + walk + vx, LO_X, HI_X);
    m_py = limit_to(m_py + vy, LO_Y, HI_Y);
    m_vx = vx;
    m_vy = vy;

    if (m_state == ST_CHARGE) m_charge = m_charge + int'(CHARGE_STEP);
    else if (m_state == ST_JUMP) m_charge = int'(CHARGE_INIT);
    if (bounce) m_face = -m_face;
    else if (m_state == ST_WALK_LEFT) m_face = 1;
    else if (m_state == ST_WALK_RIGHT) m_face = -1;

    // one new flag per edge, left first
    if (take_now) begin
        m_left_p  = 1'b0;
        m_right_p = 1'b0;
        m_jump_p  = 1'b0;
    end else if (l && !m_left_q) m_left_p = 1'b1;
    else if (r && !m_right_q) m_right_p = 1'b1;
    else if (j && !m_jump_q) m_jump_p = 1'b1;
    m_left_q  = l;
    m_right_q = r;
    m_jump_q  = j;
    m_state   = nxt;
endtask

`endif

/* tb_character.sv */
// ----------------------------------------
// testbench for the character top level
// directed moves, then a random run
// checked against the reference model
// ----------------------------------------
`timescale 1ns/1ps

module tb_character;
    import character_pkg::*;

    localparam int          RAND_CYCLES = 4000;
    localparam int          TIMEOUT_NS  = (RAND_CYCLES + 200) * 10 + 500;
    localparam logic [31:0] SEED        = 32'h097c90d8;

    logic        character_clk;
    logic        sys_rst_n;
    logic        left_btn, right_btn, jump_btn;
    phys_t       pos_x, pos_y, vel_x, vel_y;
    face_t       face;
    logic        on_ground, charging;
    int          errors;
    int          cycles;
    logic [31:0] rnd;

    `include "character_model.svh"

    character_top dut (
        .character_clk (character_clk),
        .sys_rst_n     (sys_rst_n),
        .left_btn      (left_btn),
        .right_btn     (right_btn),
        .jump_btn      (jump_btn),
        .pos_x         (pos_x),
        .pos_y         (pos_y),
        .vel_x         (vel_x),
        .vel_y         (vel_y),
        .face          (face),
        .on_ground     (on_ground),
        .charging      (charging)
    );

    initial begin
        character_clk = 1'b0;
        forever #5 character_clk = ~character_clk;
    end

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_mismatch(input string name, input int exp, input int act);
        errors++;
        $display("[ERROR] %0t: %s expected %0d, got %0d", $time, name, exp, act);
    endtask

    task automatic compare_outputs();
        if (pos_x !== phys_t'(m_px))
            report_mismatch("pos_x", m_px, int'(pos_x));
        if (pos_y !== phys_t'(m_py))
            report_mismatch("pos_y", m_py, int'(pos_y));
        if (vel_x !== phys_t'(m_vx))
            report_mismatch("vel_x", m_vx, int'(vel_x));
        if (vel_y !== phys_t'(m_vy))
            report_mismatch("vel_y", m_vy, int'(vel_y));
        if (face !== face_t'(m_face))
            report_mismatch("face", m_face, int'(face));
        if (on_ground !== (m_py == LO_Y))
            report_mismatch("on_ground", int'(m_py == LO_Y), int'(on_ground));
        if (charging !== (m_state == ST_CHARGE))
            report_mismatch("charging", int'(m_state == ST_CHARGE), int'(charging));
        // interior and speed limits
        if (int'(pos_x) < LO_X || int'(pos_x) > HI_X ||
            int'(pos_y) < LO_Y || int'(pos_y) > HI_Y ||
            int'(vel_x) > VMAX || int'(vel_x) < -VMAX ||
            int'(vel_y) > VMAX || int'(vel_y) < -VMAX) begin
            errors++;
            $display("[ERROR] %0t: position or velocity outside the limits", $time);
        end
    endtask

    // called at a falling edge, returns at the next one
    task automatic apply_cycle(input logic l, input logic r, input logic j);
        left_btn  = l;
        right_btn = r;
        jump_btn  = j;
        @(posedge character_clk);
        model_step(l, r, j);
        @(negedge character_clk);
        compare_outputs();
        cycles++;
    endtask

    task automatic walk_check(input logic go_left);
        int start_x;
        int step;
        start_x = m_px;
        step    = go_left ? int'(WALK_LEFT_STEP) : int'(WALK_RIGHT_STEP);
        apply_cycle(go_left, !go_left, 1'b0);   // press seen at edge k
        apply_cycle(1'b0, 1'b0, 1'b0);          // command taken at edge k+1
        if (int'(pos_x) != start_x)
            report_mismatch("pos_x before walk", start_x, int'(pos_x));
        apply_cycle(1'b0, 1'b0, 1'b0);          // step applied at edge k+2
        if (int'(pos_x) != start_x + step)
            report_mismatch("pos_x after walk", start_x + step, int'(pos_x));
        if (int'(face) != (go_left ? 1 : -1))
            report_mismatch("face after walk", go_left ? 1 : -1, int'(face));
    endtask

    initial begin
        int   land_cycles;
        int   jump_left;
        logic j;
        left_btn  = 1'b0;
        right_btn = 1'b0;
        jump_btn  = 1'b0;
        sys_rst_n = 1'b0;
        errors    = 0;
        cycles    = 0;
        jump_left = 0;
        rnd       = SEED;
        model_reset();
        repeat (3) @(negedge character_clk);
        sys_rst_n = 1'b1;
        compare_outputs();

        // fall from the start position onto the floor
        land_cycles = 0;
        while (!(on_ground === 1'b1 && vel_y == '0) && land_cycles < 60) begin
            apply_cycle(1'b0, 1'b0, 1'b0);
            land_cycles++;
        end
        if (on_ground !== 1'b1 || vel_y !== '0) begin
            errors++;
            $display("the character did not land within 60 cycles after reset");
        end

        walk_check(1'b1);
        walk_check(1'b0);

        // charge, release, then a right press while airborne
        repeat (3) apply_cycle(1'b0, 1'b0, 1'b1);
        if (charging !== 1'b1)
            report_mismatch("charging while held", 1, int'(charging));
        repeat (3) apply_cycle(1'b0, 1'b0, 1'b1);
        repeat (4) apply_cycle(1'b0, 1'b0, 1'b0);
        apply_cycle(1'b0, 1'b1, 1'b0);
        repeat (80) apply_cycle(1'b0, 1'b0, 1'b0);

        // short walk presses, jumps held for a random length
        for (int i = 0; i < RAND_CYCLES; i++) begin
            rnd = next_rand(rnd);
            if (jump_left > 0) begin
                jump_left--;
                j = 1'b1;
            end else if (rnd[13:8] == 6'd0) begin
                jump_left = int'(rnd[19:16]);
                j = 1'b1;
            end else begin
                j = 1'b0;
            end
            apply_cycle(rnd[3:0] == 4'd0, rnd[7:4] == 4'd1, j);
        end

        $display("test finished after %0d cycles with %0d errors", cycles, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog: the run timed out before the tests finished");
        $display("Errors found");
        $finish;
    end

endmodule

/* character_top.sv */
// ----------------------------------------
// character top level
// sampler, movement FSM and physics step
// ----------------------------------------
`timescale 1ns/1ps

module character_top (
    input  logic                 character_clk,
    input  logic                 sys_rst_n,
    input  logic                 left_btn,
    input  logic                 right_btn,
    input  logic                 jump_btn,
    output character_pkg::phys_t pos_x,
    output character_pkg::phys_t pos_y,
    output character_pkg::phys_t vel_x,
    output character_pkg::phys_t vel_y,
    output character_pkg::face_t face,
    output logic                 on_ground,
    output logic                 charging
);
    import character_pkg::*;

    cmd_if    cmd ();
    motion_if motion ();

    button_sampler u_sampler (
        .character_clk (character_clk),
        .sys_rst_n     (sys_rst_n),
        .left_btn      (left_btn),
        .right_btn     (right_btn),
        .jump_btn      (jump_btn),
        .cmd           (cmd.sampler)
    );

    jump_fsm u_fsm (
        .character_clk (character_clk),
        .sys_rst_n     (sys_rst_n),
        .cmd           (cmd.fsm),
        .motion        (motion.fsm)
    );

    character_physics u_physics (
        .character_clk (character_clk),
        .sys_rst_n     (sys_rst_n),
        .motion        (motion.physics),
        .pos_x         (pos_x),
        .pos_y         (pos_y),
        .vel_x         (vel_x),
        .vel_y         (vel_y)
    );

    assign face      = motion.face;
    assign on_ground = motion.on_ground;
    assign charging  = (motion.state == ST_CHARGE);

endmodule

/* character_physics.sv */
// ----------------------------------------
// contact detect against the interior limits
// velocity update with saturation
// position update with clamping
// ----------------------------------------
`timescale 1ns/1ps

module character_physics (
    input  logic                 character_clk,
    input  logic                 sys_rst_n,
    motion_if.physics            motion,
    output character_pkg::phys_t pos_x,
    output character_pkg::phys_t pos_y,
    output character_pkg::phys_t vel_x,
    output character_pkg::phys_t vel_y
);
    import character_pkg::*;

    logic  on_ground;
    logic  landing;
    logic  ceiling_hit;
    logic  side_bounce;
    phys_t factor_s;                         // jump factor as signed
    phys_t face_s;
    phys_t vx_hit, vy_hit;                   // after contact response
    phys_t imp_x, imp_y;
    phys_t grav_y;
    phys_t vx_new, vy_new;
    phys_t step_x;
    phys_t pos_x_new, pos_y_new;

    // limit a value to lo..hi
    function automatic phys_t clamp(input phys_t v, input phys_t lo, input phys_t hi);
        phys_t r;
        if (v < lo) begin
            r = lo;
        end else if (v > hi) begin
            r = hi;
        end else begin
            r = v;
        end
        return r;
    endfunction

    // ----------------------------------------
    // contacts
    // ----------------------------------------
    // clamp keeps the body out of the walls, so equality is enough
    assign on_ground   = (pos_y == Y_MIN);
    assign landing     = on_ground && (vel_y < 0);
    assign ceiling_hit = (pos_y == Y_MAX) && (vel_y > 0);
    assign side_bounce = ((pos_x == X_MAX) && (vel_x > 0)) ||
                         ((pos_x == X_MIN) && (vel_x < 0));

    always_comb begin
        if (landing) begin
            vx_hit = '0;                     // landing stops both axes
        end else if (side_bounce) begin
            vx_hit = -vel_x;
        end else begin
            vx_hit = vel_x;
        end

        if (landing) begin
            vy_hit = '0;
        end else if (ceiling_hit) begin
            vy_hit = -vel_y;
        end else begin
            vy_hit = vel_y;
        end
    end

    // ----------------------------------------
    // impulse, gravity, saturation
    // ----------------------------------------
    assign factor_s = phys_t'(motion.jump_factor);
    assign face_s   = phys_t'(motion.face);

    always_comb begin
        if (motion.state == ST_JUMP) begin
            imp_x = JUMP_VEL_X * factor_s * face_s;
            imp_y = JUMP_VEL_Y * factor_s;
        end else begin
            imp_x = '0;
            imp_y = '0;
        end
    end

    assign grav_y = on_ground ? phys_t'(0) : GRAVITY;

    assign vx_new = clamp(vx_hit + imp_x, -MAX_VEL, MAX_VEL);
    assign vy_new = clamp(vy_hit + imp_y + grav_y, -MAX_VEL, MAX_VEL);

    // ----------------------------------------
    // position
    // ----------------------------------------
    always_comb begin
        case (motion.state)
            ST_WALK_LEFT:  step_x = WALK_LEFT_STEP;
            ST_WALK_RIGHT: step_x = WALK_RIGHT_STEP;
            default:       step_x = '0;
        endcase
    end

    assign pos_x_new = clamp(pos_x + step_x + vx_new, X_MIN, X_MAX);
    assign pos_y_new = clamp(pos_y + vy_new, Y_MIN, Y_MAX);

    always_ff @(posedge character_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            vel_x <= '0;
            vel_y <= '0;
            pos_x <= INIT_X;
            pos_y <= INIT_Y;
        end else begin
            vel_x <= vx_new;
            vel_y <= vy_new;
            pos_x <= pos_x_new;
            pos_y <= pos_y_new;
        end
    end

    assign motion.on_ground   = on_ground;
    assign motion.side_bounce = side_bounce;

endmodule

/* jump_fsm.sv */
// ----------------------------------------
// movement FSM with charge counter
// jump factor bands and facing direction
// ----------------------------------------
`timescale 1ns/1ps

module jump_fsm (
    input  logic  character_clk,
    input  logic  sys_rst_n,
    cmd_if.fsm    cmd,
    motion_if.fsm motion
);
    import character_pkg::*;

    move_state_t  state;
    move_state_t  state_next;
    charge_t      charge;
    jump_factor_t jump_factor;
    face_t        face;
    logic         take;
    logic         charge_done;

    // release or full charge ends the charge
    assign charge_done = (charge >= MAX_CHARGE) || !cmd.jump_held;

    // ----------------------------------------
    // next state and command take
    // ----------------------------------------
    always_comb begin
        state_next = ST_IDLE;
        take       = 1'b0;
        case (state)
            ST_IDLE, ST_WALK_LEFT, ST_WALK_RIGHT: begin
                // commands only accepted on the ground
                if (motion.on_ground) begin
                    if (cmd.left_pending) begin
                        state_next = ST_WALK_LEFT;
                        take       = 1'b1;
                    end else if (cmd.right_pending) begin
                        state_next = ST_WALK_RIGHT;
                        take       = 1'b1;
                    end else if (cmd.jump_pending) begin
                        state_next = ST_CHARGE;
                        take       = 1'b1;
                    end
                end
            end
            ST_CHARGE: begin
                state_next = charge_done ? ST_JUMP : ST_CHARGE;
            end
            default: begin
                state_next = ST_IDLE;        // jump is a single cycle
            end
        endcase
    end

    always_ff @(posedge character_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // ----------------------------------------
    // charge and jump strength
    // ----------------------------------------
    always_ff @(posedge character_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            charge <= CHARGE_INIT;
        end else if (state == ST_CHARGE) begin
            charge <= charge + CHARGE_STEP;
        end else if (state == ST_JUMP) begin
            charge <= CHARGE_INIT;           // ready for the next charge
        end
    end

    always_comb begin
        if (charge <= CHARGE_BAND_1) begin
            jump_factor = 3'd1;
        end else if (charge <= CHARGE_BAND_2) begin
            jump_factor = 3'd2;
        end else if (charge <= CHARGE_BAND_3) begin
            jump_factor = 3'd3;
        end else begin
            jump_factor = 3'd4;
        end
    end

    // wall bounce turns the character around
    always_ff @(posedge character_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            face <= FACE_LEFT;
        end else if (motion.side_bounce) begin
            face <= -face;
        end else if (state == ST_WALK_LEFT) begin
            face <= FACE_LEFT;
        end else if (state == ST_WALK_RIGHT) begin
            face <= FACE_RIGHT;
        end
    end

    assign cmd.take           = take;
    assign motion.state       = state;
    assign motion.jump_factor = jump_factor;
    assign motion.face        = face;

endmodule

/* button_sampler.sv */
// ----------------------------------------
// button sampling and rising edge detect
// one-deep pending command latch
// ----------------------------------------
`timescale 1ns/1ps

module button_sampler (
    input  logic   character_clk,
    input  logic   sys_rst_n,
    input  logic   left_btn,
    input  logic   right_btn,
    input  logic   jump_btn,
    cmd_if.sampler cmd
);

    logic left_d, right_d, jump_d;           // previous samples
    logic left_rise, right_rise, jump_rise;
    logic left_pend, right_pend, jump_pend;

    always_ff @(posedge character_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            left_d  <= 1'b0;
            right_d <= 1'b0;
            jump_d  <= 1'b0;
        end else begin
            left_d  <= left_btn;
            right_d <= right_btn;
            jump_d  <= jump_btn;
        end
    end

    // high now, low at the previous edge
    assign left_rise  = left_btn & ~left_d;
    assign right_rise = right_btn & ~right_d;
    assign jump_rise  = jump_btn & ~jump_d;

    // ----------------------------------------
    // pending flags
    // ----------------------------------------
    // only one flag set per edge, left first
    always_ff @(posedge character_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            left_pend  <= 1'b0;
            right_pend <= 1'b0;
            jump_pend  <= 1'b0;
        end else if (cmd.take) begin
            left_pend  <= 1'b0;              // take clears all three
            right_pend <= 1'b0;
            jump_pend  <= 1'b0;
        end else if (left_rise) begin
            left_pend  <= 1'b1;
        end else if (right_rise) begin
            right_pend <= 1'b1;
        end else if (jump_rise) begin
            jump_pend  <= 1'b1;
        end
    end

    assign cmd.left_pending  = left_pend;
    assign cmd.right_pending = right_pend;
    assign cmd.jump_pending  = jump_pend;
    assign cmd.jump_held     = jump_d;

endmodule

/* character_ifs.sv */
// ----------------------------------------
// cmd_if     button commands to the FSM
// motion_if  FSM state to the physics step
// ----------------------------------------
`timescale 1ns/1ps

interface cmd_if;
    logic left_pending;
    logic right_pending;
    logic jump_pending;
    logic jump_held;    // registered jump button level
    logic take;         // one-cycle pulse that clears all pending flags

    modport sampler (
        output left_pending, right_pending, jump_pending, jump_held,
        input  take
    );

    modport fsm (
        input  left_pending, right_pending, jump_pending, jump_held,
        output take
    );
endinterface

interface motion_if;
    import character_pkg::*;

    move_state_t  state;
    jump_factor_t jump_factor;
    face_t        face;
    logic         on_ground;
    logic         side_bounce;

    modport fsm (
        output state, jump_factor, face,
        input  on_ground, side_bounce
    );

    modport physics (
        input  state, jump_factor, face,
        output on_ground, side_bounce
    );
endinterface

/* character_pkg.sv */
// ----------------------------------------
// shared constants and types for the character
// map geometry, physics limits, charge bands
// movement state enum and value types
// ----------------------------------------
package character_pkg;

    // 11-bit signed value for position, velocity and steps
    typedef logic signed [10:0] phys_t;

    typedef logic [6:0] charge_t;            // charge counter
    typedef logic [2:0] jump_factor_t;       // 1 to 4
    typedef logic signed [1:0] face_t;       // +1 left, -1 right

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WALK_LEFT,
        ST_WALK_RIGHT,
        ST_CHARGE,
        ST_JUMP
    } move_state_t;

    // ----------------------------------------
    // map geometry
    // ----------------------------------------
    localparam int MAP_X_OFFSET = 270;
    localparam int MAP_Y_OFFSET = 50;
    localparam int MAP_SIZE     = 100;
    localparam int WALL_WIDTH   = 10;
    localparam int CHAR_SIZE    = 32;

    // clamp bounds of the character corner
    localparam phys_t X_MIN = phys_t'(MAP_X_OFFSET + WALL_WIDTH);
    localparam phys_t X_MAX = phys_t'(MAP_X_OFFSET + MAP_SIZE - WALL_WIDTH - CHAR_SIZE);
    localparam phys_t Y_MIN = phys_t'(MAP_Y_OFFSET + WALL_WIDTH);
    localparam phys_t Y_MAX = phys_t'(MAP_Y_OFFSET + MAP_SIZE - WALL_WIDTH - CHAR_SIZE);

    localparam phys_t INIT_X = phys_t'(MAP_X_OFFSET + (MAP_SIZE - CHAR_SIZE) / 2);
    localparam phys_t INIT_Y = phys_t'(MAP_Y_OFFSET + (MAP_SIZE - CHAR_SIZE) / 2);

    // ----------------------------------------
    // physics
    // ----------------------------------------
    // keeps one step shorter than wall plus body, so no tunnelling
    localparam phys_t MAX_VEL = phys_t'(WALL_WIDTH + CHAR_SIZE - 2);
    localparam phys_t GRAVITY = -11'sd1;

    // x grows toward the left in this map
    localparam phys_t WALK_LEFT_STEP  = 11'sd1;
    localparam phys_t WALK_RIGHT_STEP = -11'sd1;

    localparam phys_t JUMP_VEL_X = 11'sd4;
    localparam phys_t JUMP_VEL_Y = 11'sd8;

    localparam face_t FACE_LEFT  = 2'sb01;
    localparam face_t FACE_RIGHT = 2'sb11;

    // charge counter and the four jump bands
    localparam charge_t MAX_CHARGE    = 7'd100;
    localparam charge_t CHARGE_STEP   = 7'd10;
    localparam charge_t CHARGE_INIT   = 7'd1;
    localparam charge_t CHARGE_BAND_1 = charge_t'(MAX_CHARGE / 4);
    localparam charge_t CHARGE_BAND_2 = charge_t'(MAX_CHARGE / 2);
    localparam charge_t CHARGE_BAND_3 = charge_t'((3 * int'(MAX_CHARGE)) / 4);

endpackage
